// File: vlog.f
source/ntm_math_pkg.sv
source/ntm_credit_fifo.sv
source/ntm_scalar_multiplier.sv
source/ntm_vector_multiplication.sv
source/ntm_matrix_multiplication.sv
source/ntm_matrix_multiplication_top.sv
sim/ntm_matrix_multiplication_assertions.sv
sim/ntm_matrix_multiplication_tb.sv

// File: sim/ntm_matrix_multiplication_tb.sv
`timescale 1ns/1ps

module ntm_matrix_multiplication_tb;

  localparam int INDEX_WIDTH   = 8;
  localparam int OPERAND_DEPTH = 4;
  localparam int RESULT_DEPTH  = 4;
  localparam int JOB_TIMEOUT   = 20000;
  localparam int DRAIN_TIMEOUT = 20000;

  logic                   CLK;
  logic                   RST;
  logic                   START;
  logic                   READY;
  logic [INDEX_WIDTH-1:0] size_i;
  logic [INDEX_WIDTH-1:0] size_j;
  ntm_math_pkg::word_t    modulo;
  logic                   operand_valid;
  ntm_math_pkg::operand_t operand;
  logic                   operand_credit;
  logic                   result_valid;
  ntm_math_pkg::result_t  result;
  logic                   result_credit;

  // Scoreboard state
  ntm_math_pkg::operand_t ops_q[$];
  ntm_math_pkg::result_t  exp_q[$];
  string                  test_name;
  int                     credits;
  int                     checks;
  int                     errors;
  int                     received;
  int                     total_expected;
  int                     jobs_started;
  int                     ready_total;
  bit                     sink_stall;

  ntm_matrix_multiplication_top #(
    .INDEX_WIDTH  (INDEX_WIDTH),
    .OPERAND_DEPTH(OPERAND_DEPTH),
    .RESULT_DEPTH (RESULT_DEPTH)
  ) ntm_matrix_multiplication_top_i (
    .CLK           (CLK),
    .RST           (RST),
    .START         (START),
    .READY         (READY),
    .size_i        (size_i),
    .size_j        (size_j),
    .modulo        (modulo),
    .operand_valid (operand_valid),
    .operand       (operand),
    .operand_credit(operand_credit),
    .result_valid  (result_valid),
    .result        (result),
    .result_credit (result_credit)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //////////////////////////////
  // Reference and checking
  //////////////////////////////

  // Full 64-bit product, then reduce
  function automatic ntm_math_pkg::word_t reference_product(input ntm_math_pkg::word_t a,
                                                            input ntm_math_pkg::word_t b,
                                                            input ntm_math_pkg::word_t m);
    logic [63:0] wide;
    wide = {32'b0, a} * {32'b0, b};
    return ntm_math_pkg::word_t'(wide % {32'b0, m});
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Every issued result against the head of the expected queue
  initial begin : compare_results
    ntm_math_pkg::result_t expected;
    forever begin
      @(negedge CLK);
      if (!RST && result_valid) begin
        received++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error: %s produced a result that was not expected", test_name);
        end else begin
          expected = exp_q.pop_front();
          check_value({test_name, " data"}, expected.data, result.data);
          check_value({test_name, " last_column"}, expected.last_column, result.last_column);
          check_value({test_name, " last_row"}, expected.last_row, result.last_row);
        end
      end
    end
  end

  // Sink holds results, hands slots back at random in stall mode
  initial begin : sink_credits
    int held;
    held = 0;
    result_credit = 1'b0;
    forever begin
      @(negedge CLK);
      if (RST) begin
        held = 0;
        result_credit = 1'b0;
      end else begin
        if (result_valid) begin
          held++;
        end
        if (held > 0 && (!sink_stall || $urandom_range(15) == 0)) begin
          result_credit = 1'b1;
          held--;
        end else begin
          result_credit = 1'b0;
        end
      end
    end
  end

  initial begin : count_ready
    forever begin
      @(negedge CLK);
      if (!RST && READY) begin
        ready_total++;
      end
    end
  end

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  task automatic add_operands(input ntm_math_pkg::word_t a, input ntm_math_pkg::word_t b);
    ntm_math_pkg::operand_t op;
    op.multiplicand = a;
    op.multiplier   = b;
    ops_q.push_back(op);
  endtask

  // Operands below the modulus only
  task automatic fill_random(input int count, input ntm_math_pkg::word_t m);
    for (int k = 0; k < count; k++) begin
      add_operands($urandom % m, $urandom % m);
    end
  endtask

  // Start one job, feed ops_q under credit, return on READY
  task automatic run_job(input string name, input int rows, input int cols,
                         input ntm_math_pkg::word_t m, input bit gaps);
    ntm_math_pkg::result_t exp;
    int sent;
    int cycles;
    bit ready_seen;
    test_name = name;
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        exp.data = reference_product(ops_q[r * cols + c].multiplicand,
                                     ops_q[r * cols + c].multiplier, m);
        exp.last_column = (c == cols - 1);
        exp.last_row    = (r == rows - 1);
        exp_q.push_back(exp);
      end
    end
    total_expected += rows * cols;
    jobs_started++;
    START  = 1'b1;
    size_i = INDEX_WIDTH'(rows);
    size_j = INDEX_WIDTH'(cols);
    modulo = m;
    sent = 0;
    cycles = 0;
    ready_seen = 1'b0;
    while (!ready_seen && cycles < JOB_TIMEOUT) begin
      if (sent < ops_q.size() && credits > 0 && (!gaps || $urandom_range(2) == 0)) begin
        operand_valid = 1'b1;
        operand = ops_q[sent];
        sent++;
        credits--;
      end else begin
        operand_valid = 1'b0;
      end
      // Credit usable only after the pop has happened
      if (operand_credit) begin
        credits++;
      end
      @(negedge CLK);
      START = 1'b0;
      ready_seen = READY;
      cycles++;
    end
    operand_valid = 1'b0;
    if (!ready_seen) begin
      errors++;
      $display("Error: %s timed out waiting for READY", name);
    end
    ops_q.delete();
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() > 0 && cycles < DRAIN_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("Error: %s timed out with %0d results missing", test_name, exp_q.size());
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(32'h97fe));
    RST = 1'b1;
    START = 1'b0;
    size_i = '0;
    size_j = '0;
    modulo = '0;
    operand_valid = 1'b0;
    operand = '0;
    sink_stall = 1'b0;
    credits = OPERAND_DEPTH;
    checks = 0;
    errors = 0;
    received = 0;
    total_expected = 0;
    jobs_started = 0;
    ready_total = 0;
    test_name = "reset";
    repeat (3) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);

    // Single element
    add_operands(32'd5, 32'd7);
    run_job("single", 1, 1, 32'd97, 1'b0);
    wait_drain();

    // Full throughput 3x4
    fill_random(12, 32'h7fff_ffff);
    run_job("random 3x4", 3, 4, 32'h7fff_ffff, 1'b0);
    wait_drain();

    // Edge operands near the top of the word
    add_operands(32'd0, 32'hffff_fffa);
    add_operands(32'd1, 32'hffff_fffa);
    add_operands(32'hffff_fffa, 32'hffff_fffa);
    add_operands(32'hffff_fffa, 32'd1);
    add_operands(32'hffff_fffa, 32'hffff_fff9);
    add_operands(32'hffff_fffa, 32'd0);
    run_job("edge prime", 2, 3, 32'hffff_fffb, 1'b0);
    wait_drain();
    add_operands(32'hffff_fffe, 32'hffff_fffe);
    add_operands(32'd1, 32'hffff_fffe);
    add_operands(32'd0, 32'd0);
    run_job("edge all ones", 1, 3, 32'hffff_ffff, 1'b0);
    wait_drain();

    // Sink withholds credits
    sink_stall = 1'b1;
    fill_random(12, 32'h8000_0001);
    run_job("result stall", 3, 4, 32'h8000_0001, 1'b0);
    wait_drain();
    sink_stall = 1'b0;

    // Source gaps, two jobs back to back
    fill_random(6, 32'h0001_0001);
    run_job("starve a", 2, 3, 32'h0001_0001, 1'b1);
    fill_random(8, 32'hfff0_0001);
    run_job("starve b", 4, 2, 32'hfff0_0001, 1'b1);
    wait_drain();
    repeat (4) @(negedge CLK);

    test_name = "summary";
    check_value("result count", total_expected, received);
    check_value("ready pulses", jobs_started, ready_total);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: sim/ntm_matrix_multiplication_assertions.sv
`timescale 1ns/1ps

module ntm_matrix_multiplication_assertions #(
  parameter int OPERAND_DEPTH = 4,
  parameter int RESULT_DEPTH  = 4
) (
  input logic CLK,
  input logic RST,
  input logic READY,
  input logic operand_valid,
  input logic operand_credit,
  input logic result_valid,
  input logic result_credit
);

  // Credits as seen from each side of the streams
  int source_credits;
  int sink_credits;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      source_credits <= OPERAND_DEPTH;
      sink_credits   <= RESULT_DEPTH;
    end else begin
      source_credits <= source_credits - int'(operand_valid) + int'(operand_credit);
      sink_credits   <= sink_credits - int'(result_valid) + int'(result_credit);
    end
  end

  //////////////////////////////
  // Operand stream
  //////////////////////////////

  operand_within_credit: assert property (
    @(posedge CLK) disable iff (RST) operand_valid |-> source_credits > 0
  ) else $error("operand sent with no credit left");

  operand_credit_bounded: assert property (
    @(posedge CLK) disable iff (RST) source_credits <= OPERAND_DEPTH
  ) else $error("more operand credits returned than operands sent");

  //////////////////////////////
  // Result stream
  //////////////////////////////

  result_within_credit: assert property (
    @(posedge CLK) disable iff (RST) result_valid |-> sink_credits > 0
  ) else $error("result issued with no sink credit left");

  // Done strobe is a single cycle
  ready_is_pulse: assert property (
    @(posedge CLK) disable iff (RST) READY |=> !READY
  ) else $error("READY held longer than one cycle");

endmodule

bind ntm_matrix_multiplication_top ntm_matrix_multiplication_assertions #(
  .OPERAND_DEPTH(OPERAND_DEPTH),
  .RESULT_DEPTH (RESULT_DEPTH)
) assertions_i (
  .CLK           (CLK),
  .RST           (RST),
  .READY         (READY),
  .operand_valid (operand_valid),
  .operand_credit(operand_credit),
  .result_valid  (result_valid),
  .result_credit (result_credit)
);

// File: source/ntm_matrix_multiplication_top.sv
`timescale 1ns/1ps

module ntm_matrix_multiplication_top #(
  parameter int INDEX_WIDTH   = 8,
  parameter int OPERAND_DEPTH = 4,
  parameter int RESULT_DEPTH  = 4
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  output logic                   READY,
  input  logic [INDEX_WIDTH-1:0] size_i,
  input  logic [INDEX_WIDTH-1:0] size_j,
  input  ntm_math_pkg::word_t    modulo,
  input  logic                   operand_valid,
  input  ntm_math_pkg::operand_t operand,
  output logic                   operand_credit,
  output logic                   result_valid,
  output ntm_math_pkg::result_t  result,
  input  logic                   result_credit
);

  // Operand path
  ntm_math_pkg::operand_t operand_head;
  logic                   operand_empty;
  logic                   operand_pop;

  // Result path
  ntm_math_pkg::result_t  result_data;
  ntm_math_pkg::result_t  result_head;
  logic                   result_push;
  logic                   result_full;
  logic                   result_empty;
  logic                   result_pop;

  // Source obeys its credits, full never seen
  ntm_credit_fifo #(
    .DEPTH  (OPERAND_DEPTH),
    .entry_t(ntm_math_pkg::operand_t)
  ) operand_fifo (
    .CLK      (CLK),
    .RST      (RST),
    .push     (operand_valid),
    .push_data(operand),
    .full     (),
    .pop      (operand_pop),
    .pop_data (operand_head),
    .empty    (operand_empty),
    .credit   (operand_credit)
  );

  // Sink credits tracked in the controller
  ntm_credit_fifo #(
    .DEPTH  (RESULT_DEPTH),
    .entry_t(ntm_math_pkg::result_t)
  ) result_fifo (
    .CLK      (CLK),
    .RST      (RST),
    .push     (result_push),
    .push_data(result_data),
    .full     (result_full),
    .pop      (result_pop),
    .pop_data (result_head),
    .empty    (result_empty),
    .credit   ()
  );

  ntm_matrix_multiplication #(
    .INDEX_WIDTH (INDEX_WIDTH),
    .RESULT_DEPTH(RESULT_DEPTH)
  ) matrix_multiplication_i (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .READY        (READY),
    .size_i       (size_i),
    .size_j       (size_j),
    .modulo       (modulo),
    .operand_empty(operand_empty),
    .operand_pop  (operand_pop),
    .operand      (operand_head),
    .result_full  (result_full),
    .result_push  (result_push),
    .result_data  (result_data),
    .result_empty (result_empty),
    .result_pop   (result_pop),
    .result_credit(result_credit),
    .result_valid (result_valid)
  );

  // FIFO head registered in step with result_valid
  always_ff @(posedge CLK) begin
    if (result_pop) begin
      result <= result_head;
    end
  end

endmodule

// File: source/ntm_matrix_multiplication.sv
`timescale 1ns/1ps

module ntm_matrix_multiplication #(
  parameter int INDEX_WIDTH  = 8,
  parameter int RESULT_DEPTH = 4
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   START,
  output logic                   READY,
  input  logic [INDEX_WIDTH-1:0] size_i,
  input  logic [INDEX_WIDTH-1:0] size_j,
  input  ntm_math_pkg::word_t    modulo,
  input  logic                   operand_empty,
  output logic                   operand_pop,
  input  ntm_math_pkg::operand_t operand,
  input  logic                   result_full,
  output logic                   result_push,
  output ntm_math_pkg::result_t  result_data,
  input  logic                   result_empty,
  output logic                   result_pop,
  input  logic                   result_credit,
  output logic                   result_valid
);

  localparam int CREDIT_WIDTH = $clog2(RESULT_DEPTH + 1);

  ntm_math_pkg::matrix_state_t state;

  // Captured job
  logic [INDEX_WIDTH-1:0] size_i_q;
  logic [INDEX_WIDTH-1:0] size_j_q;
  ntm_math_pkg::word_t    modulo_q;

  logic [INDEX_WIDTH-1:0] row;
  logic                   last_row;
  logic                   row_start;
  logic                   row_done;

  // Free slots on the sink side
  logic [CREDIT_WIDTH-1:0] credits;

  assign last_row   = (row == size_i_q - 1'b1);
  assign result_pop = !result_empty && (credits != '0);

  //////////////////////////////
  // Row loop
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ntm_math_pkg::MATRIX_IDLE;
      row       <= '0;
      size_i_q  <= '0;
      size_j_q  <= '0;
      row_start <= 1'b0;
      READY     <= 1'b0;
    end else begin
      row_start <= 1'b0;
      READY     <= 1'b0;
      case (state)
        ntm_math_pkg::MATRIX_IDLE: begin
          if (START) begin
            size_i_q  <= size_i;
            size_j_q  <= size_j;
            row       <= '0;
            row_start <= 1'b1;
            state     <= ntm_math_pkg::MATRIX_ROW;
          end
        end
        ntm_math_pkg::MATRIX_ROW: begin
          // Rows never overlap, next one waits for row_done
          if (row_done) begin
            if (last_row) begin
              state <= ntm_math_pkg::MATRIX_DRAIN;
            end else begin
              row       <= row + 1'b1;
              row_start <= 1'b1;
            end
          end
        end
        ntm_math_pkg::MATRIX_DRAIN: begin
          // Final result sits in the FIFO
          READY <= 1'b1;
          state <= ntm_math_pkg::MATRIX_IDLE;
        end
        default: state <= ntm_math_pkg::MATRIX_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (state == ntm_math_pkg::MATRIX_IDLE && START) begin
      modulo_q <= modulo;
    end
  end

  //////////////////////////////
  // Result credits
  //////////////////////////////

  // Spent at the pop so a valid in flight is already counted
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credits      <= CREDIT_WIDTH'(RESULT_DEPTH);
      result_valid <= 1'b0;
    end else begin
      credits      <= credits + CREDIT_WIDTH'(result_credit) - CREDIT_WIDTH'(result_pop);
      result_valid <= result_pop;
    end
  end

  ntm_vector_multiplication #(
    .INDEX_WIDTH(INDEX_WIDTH)
  ) vector_multiplication_i (
    .CLK          (CLK),
    .RST          (RST),
    .row_start    (row_start),
    .last_row     (last_row),
    .size_j       (size_j_q),
    .modulo       (modulo_q),
    .row_done     (row_done),
    .operand_empty(operand_empty),
    .operand_pop  (operand_pop),
    .operand      (operand),
    .result_full  (result_full),
    .result_push  (result_push),
    .result       (result_data)
  );

endmodule

// File: source/ntm_vector_multiplication.sv
`timescale 1ns/1ps

module ntm_vector_multiplication #(
  parameter int INDEX_WIDTH = 8
) (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   row_start,
  input  logic                   last_row,
  input  logic [INDEX_WIDTH-1:0] size_j,
  input  ntm_math_pkg::word_t    modulo,
  output logic                   row_done,
  input  logic                   operand_empty,
  output logic                   operand_pop,
  input  ntm_math_pkg::operand_t operand,
  input  logic                   result_full,
  output logic                   result_push,
  output ntm_math_pkg::result_t  result
);

  ntm_math_pkg::vector_state_t state;

  logic [INDEX_WIDTH-1:0] col;
  logic                   last_row_q;
  logic                   last_column;

  // Multiplier handshake
  logic                   mult_start;
  logic                   mult_done;
  ntm_math_pkg::word_t    mult_product;

  assign last_column = (col == size_j - 1'b1);

  // Head of operand FIFO goes straight into the multiplier
  assign operand_pop = (state == ntm_math_pkg::VECTOR_FETCH) && !operand_empty;
  assign mult_start  = operand_pop;
  // Push stalls on a full result FIFO
  assign result_push = (state == ntm_math_pkg::VECTOR_PUSH) && !result_full;

  //////////////////////////////
  // Column loop
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ntm_math_pkg::VECTOR_IDLE;
      col        <= '0;
      last_row_q <= 1'b0;
      row_done   <= 1'b0;
    end else begin
      row_done <= 1'b0;
      case (state)
        ntm_math_pkg::VECTOR_IDLE: begin
          if (row_start) begin
            col        <= '0;
            last_row_q <= last_row;
            state      <= ntm_math_pkg::VECTOR_FETCH;
          end
        end
        ntm_math_pkg::VECTOR_FETCH: begin
          if (!operand_empty) begin
            state <= ntm_math_pkg::VECTOR_MULTIPLY;
          end
        end
        ntm_math_pkg::VECTOR_MULTIPLY: begin
          if (mult_done) begin
            state <= ntm_math_pkg::VECTOR_PUSH;
          end
        end
        ntm_math_pkg::VECTOR_PUSH: begin
          if (!result_full) begin
            if (last_column) begin
              row_done <= 1'b1;
              state    <= ntm_math_pkg::VECTOR_IDLE;
            end else begin
              col   <= col + 1'b1;
              state <= ntm_math_pkg::VECTOR_FETCH;
            end
          end
        end
        default: state <= ntm_math_pkg::VECTOR_IDLE;
      endcase
    end
  end

  // Tag the product as it lands
  always_ff @(posedge CLK) begin
    if (state == ntm_math_pkg::VECTOR_MULTIPLY && mult_done) begin
      result.data        <= mult_product;
      result.last_column <= last_column;
      result.last_row    <= last_row_q;
    end
  end

  ntm_scalar_multiplier scalar_multiplier_i (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mult_start),
    .operands(operand),
    .modulo  (modulo),
    .done    (mult_done),
    .product (mult_product)
  );

endmodule

// File: source/ntm_scalar_multiplier.sv
`timescale 1ns/1ps

module ntm_scalar_multiplier (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  ntm_math_pkg::operand_t   operands,
  input  ntm_math_pkg::word_t      modulo,
  output logic                     done,
  output ntm_math_pkg::word_t      product
);

  localparam int WIDTH      = ntm_math_pkg::WORD_WIDTH;
  localparam int STEP_WIDTH = $clog2(WIDTH);

  ntm_math_pkg::scalar_state_t state;

  // Working registers
  ntm_math_pkg::word_t   acc;
  ntm_math_pkg::word_t   multiplicand_q;
  ntm_math_pkg::word_t   multiplier_q;
  logic [STEP_WIDTH-1:0] step;

  // One extra bit so doubling and adding never overflow
  logic [WIDTH:0] wide_modulo;
  logic [WIDTH:0] doubled;
  logic [WIDTH:0] doubled_red;
  logic [WIDTH:0] summed;
  logic [WIDTH:0] summed_red;

  //////////////////////////////
  // One shift-add step
  //////////////////////////////

  assign wide_modulo = {1'b0, modulo};
  assign doubled     = {acc, 1'b0};
  // Accumulator below modulus, so one subtraction is enough
  assign doubled_red = (doubled >= wide_modulo) ? doubled - wide_modulo : doubled;
  // Add multiplicand for a set multiplier bit, MSB first
  assign summed      = multiplier_q[WIDTH-1] ? doubled_red + {1'b0, multiplicand_q}
                                             : doubled_red;
  assign summed_red  = (summed >= wide_modulo) ? summed - wide_modulo : summed;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_math_pkg::SCALAR_IDLE;
      step  <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ntm_math_pkg::SCALAR_IDLE: begin
          if (start) begin
            step  <= '0;
            state <= ntm_math_pkg::SCALAR_STEP;
          end
        end
        ntm_math_pkg::SCALAR_STEP: begin
          step <= step + 1'b1;
          // Last bit scanned, product valid next cycle
          if (step == STEP_WIDTH'(WIDTH - 1)) begin
            done  <= 1'b1;
            state <= ntm_math_pkg::SCALAR_IDLE;
          end
        end
        default: state <= ntm_math_pkg::SCALAR_IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (state == ntm_math_pkg::SCALAR_IDLE && start) begin
      acc            <= '0;
      multiplicand_q <= operands.multiplicand;
      multiplier_q   <= operands.multiplier;
    end else if (state == ntm_math_pkg::SCALAR_STEP) begin
      acc          <= summed_red[WIDTH-1:0];
      multiplier_q <= {multiplier_q[WIDTH-2:0], 1'b0};
      if (step == STEP_WIDTH'(WIDTH - 1)) begin
        product <= summed_red[WIDTH-1:0];
      end
    end
  end

endmodule

// File: source/ntm_credit_fifo.sv
`timescale 1ns/1ps

module ntm_credit_fifo #(
  parameter int DEPTH = 4,
  parameter type entry_t = logic
) (
  input  logic   CLK,
  input  logic   RST,
  input  logic   push,
  input  entry_t push_data,
  output logic   full,
  input  logic   pop,
  output entry_t pop_data,
  output logic   empty,
  output logic   credit
);

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  // Storage
  entry_t mem [DEPTH];

  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;

  // Requests that actually take effect
  logic do_push;
  logic do_pop;

  assign full     = (count == COUNT_WIDTH'(DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];

  // One credit back to the producer per entry freed
  assign credit = do_pop;

  // Write side, no reset on the payload
  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap explicitly, depth need not be a power of two
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + COUNT_WIDTH'(do_push) - COUNT_WIDTH'(do_pop);
    end
  end

endmodule

// File: source/ntm_math_pkg.sv
package ntm_math_pkg;

  //////////////////////////////
  // Data words
  //////////////////////////////

  // Width of operands, products and modulus
  localparam int WORD_WIDTH = 32;

  typedef logic [WORD_WIDTH-1:0] word_t;

  //////////////////////////////
  // Stream payloads
  //////////////////////////////

  // One element of A and the matching element of B
  typedef struct packed {
    word_t multiplicand;
    word_t multiplier;
  } operand_t;

  // One element of C with its position flags
  typedef struct packed {
    word_t data;
    logic  last_column;
    logic  last_row;
  } result_t;

  //////////////////////////////
  // FSM states
  //////////////////////////////

  typedef enum logic [1:0] {
    MATRIX_IDLE,
    MATRIX_ROW,
    MATRIX_DRAIN
  } matrix_state_t;

  typedef enum logic [1:0] {
    VECTOR_IDLE,
    VECTOR_FETCH,
    VECTOR_MULTIPLY,
    VECTOR_PUSH
  } vector_state_t;

  typedef enum logic {
    SCALAR_IDLE,
    SCALAR_STEP
  } scalar_state_t;

endpackage
